/* rtl/mshr_defines.svh */
/*
 * Geometry and field width macros for the MSHR table
 */
`ifndef MSHR_DEFINES_SVH
`define MSHR_DEFINES_SVH

// Table geometry
`define MSHR_SETS        4
`define MSHR_WAYS        2
`define MSHR_SET_WIDTH   2
`define MSHR_WAY_WIDTH   1

// Line address split into tag and cache set
`define NLINE_WIDTH      16
`define CACHE_SET_WIDTH  6
`define TAG_WIDTH        10

// Requester fields kept per entry
`define REQ_ID_WIDTH     4
`define SRC_ID_WIDTH     2
`define WORD_WIDTH       3

`endif

/* rtl/mshr_pkg.sv */
/*
 * MSHR field types, entry record and per-set storage row
 */
`default_nettype none

`include "mshr_defines.svh"

package mshr_pkg;

    typedef logic [`NLINE_WIDTH-1:0]     nline_t;
    typedef logic [`TAG_WIDTH-1:0]       tag_t;
    typedef logic [`CACHE_SET_WIDTH-1:0] cache_set_t;
    typedef logic [`MSHR_SET_WIDTH-1:0]  mshr_set_t;
    typedef logic [`MSHR_WAY_WIDTH-1:0]  mshr_way_t;
    typedef logic [`REQ_ID_WIDTH-1:0]    req_id_t;
    typedef logic [`SRC_ID_WIDTH-1:0]    src_id_t;
    typedef logic [`WORD_WIDTH-1:0]      word_t;

    // One outstanding refill, as kept in the register bank
    typedef struct packed {
        tag_t    tag;
        req_id_t req_id;
        src_id_t src_id;
        word_t   word_idx;
        logic    need_rsp;
        logic    is_prefetch;
    } mshr_entry_t;

    // All ways of one MSHR set
    typedef mshr_entry_t [`MSHR_WAYS-1:0] mshr_row_t;

endpackage

`default_nettype wire

/* rtl/mshr_ram_if.sv */
/*
 * Link between the MSHR control and its one-port row storage
 */
`timescale 1ns/1ps
`default_nettype none

`include "mshr_defines.svh"

interface mshr_ram_if;

    logic                  cs;
    logic                  we;
    mshr_pkg::mshr_set_t   addr;
    logic [`MSHR_WAYS-1:0] wmask;
    mshr_pkg::mshr_row_t   wdata;
    mshr_pkg::mshr_row_t   rdata;

    // Control side issues the access
    modport ctrl (output cs, output we, output addr, output wmask, output wdata,
                  input rdata);

    // Storage side answers with the registered row
    modport mem (input cs, input we, input addr, input wmask, input wdata,
                 output rdata);

endinterface

`default_nettype wire

/* rtl/mshr_regbank_1rw.sv */
/*
 * One-port register bank, per-way write mask, registered read data
 */
`timescale 1ns/1ps
`default_nettype none

`include "mshr_defines.svh"

module mshr_regbank_1rw #(
    parameter int unsigned DEPTH = 4,
    parameter type         row_t = logic
) (
    input  wire logic  clk_i,
    input  wire logic  rst_ni,
    mshr_ram_if.mem    mem_io
);

    localparam int unsigned ROW_BITS = $bits(row_t);
    localparam int unsigned WAY_BITS = ROW_BITS / `MSHR_WAYS;

    typedef logic [ROW_BITS-1:0] row_bits_t;

    row_bits_t mem_q [DEPTH];
    row_bits_t wbits;
    row_t      rdata_q;

    assign wbits = row_bits_t'(mem_io.wdata);

    // Only the ways selected by the mask are updated
    always_ff @(posedge clk_i) begin
        if (mem_io.cs && mem_io.we) begin
            for (int w = 0; w < `MSHR_WAYS; w++) begin
                if (mem_io.wmask[w]) begin
                    mem_q[mem_io.addr][w*WAY_BITS +: WAY_BITS] <=
                        wbits[w*WAY_BITS +: WAY_BITS];
                end
            end
        end
    end

    // Read data holds until the next selected access
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_q <= '0;
        end else if (mem_io.cs) begin
            rdata_q <= row_t'(mem_q[mem_io.addr]);
        end
    end

    assign mem_io.rdata = rdata_q;

endmodule

`default_nettype wire

/* rtl/mshr.sv */
/*
 * MSHR control: valid bits, cache-set fields, free-way selection,
 * hit and fullness detection, acknowledge readout
 */
`timescale 1ns/1ps
`default_nettype none

`include "mshr_defines.svh"

module mshr (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,

    output      logic                   empty_o,
    output      logic                   full_o,

    // Check
    input  wire logic                   check_i,
    input  wire mshr_pkg::nline_t       check_nline_i,
    output      logic                   hit_o,
    output      logic                   alloc_full_o,

    // Allocate
    input  wire logic                   alloc_i,
    input  wire mshr_pkg::nline_t       alloc_nline_i,
    input  wire mshr_pkg::req_id_t      alloc_req_id_i,
    input  wire mshr_pkg::src_id_t      alloc_src_id_i,
    input  wire mshr_pkg::word_t        alloc_word_i,
    input  wire logic                   alloc_need_rsp_i,
    input  wire logic                   alloc_is_prefetch_i,
    output      mshr_pkg::mshr_way_t    alloc_way_o,

    // Acknowledge
    input  wire logic                   ack_i,
    input  wire mshr_pkg::mshr_set_t    ack_set_i,
    input  wire mshr_pkg::mshr_way_t    ack_way_i,
    output      mshr_pkg::req_id_t      ack_req_id_o,
    output      mshr_pkg::src_id_t      ack_src_id_o,
    output      mshr_pkg::cache_set_t   ack_cache_set_o,
    output      mshr_pkg::tag_t         ack_tag_o,
    output      mshr_pkg::word_t        ack_word_o,
    output      logic                   ack_need_rsp_o,
    output      logic                   ack_is_prefetch_o,

    // Row storage
    mshr_ram_if.ctrl                    ram_o
);

    // Slot state kept in flip-flops
    logic [`MSHR_SETS-1:0][`MSHR_WAYS-1:0] valid_q;
    mshr_pkg::cache_set_t                  cache_set_q [`MSHR_SETS][`MSHR_WAYS];

    logic                  check;
    mshr_pkg::mshr_set_t   alloc_set;
    mshr_pkg::mshr_set_t   check_set;
    mshr_pkg::nline_t      check_nline_q;
    mshr_pkg::mshr_set_t   check_set_q;
    mshr_pkg::tag_t        check_tag_q;
    mshr_pkg::cache_set_t  check_cache_set_q;
    mshr_pkg::mshr_way_t   ack_way_q;
    mshr_pkg::cache_set_t  ack_cache_set_q;
    mshr_pkg::mshr_entry_t alloc_entry;
    mshr_pkg::mshr_entry_t ack_entry;
    mshr_pkg::mshr_row_t   rrow;
    logic [`MSHR_WAYS-1:0] hit_way;

    // Allocation wins over a simultaneous check
    assign check = check_i & ~alloc_i;

    // MSHR set is taken from the low line address bits
    assign alloc_set = alloc_nline_i[`MSHR_SET_WIDTH-1:0];
    assign check_set = check_nline_i[`MSHR_SET_WIDTH-1:0];

    assign check_set_q       = check_nline_q[`MSHR_SET_WIDTH-1:0];
    assign check_tag_q       = check_nline_q[`NLINE_WIDTH-1 -: `TAG_WIDTH];
    assign check_cache_set_q = check_nline_q[`CACHE_SET_WIDTH-1:0];

    // Lowest free way of the allocation set
    always_comb begin
        alloc_way_o = '0;
        for (int w = `MSHR_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[alloc_set][w]) begin
                alloc_way_o = mshr_pkg::mshr_way_t'(w);
            end
        end
    end

    // Entry to store, replicated on every way and selected by the mask
    always_comb begin
        alloc_entry.tag         = alloc_nline_i[`NLINE_WIDTH-1 -: `TAG_WIDTH];
        alloc_entry.req_id      = alloc_req_id_i;
        alloc_entry.src_id      = alloc_src_id_i;
        alloc_entry.word_idx    = alloc_word_i;
        alloc_entry.need_rsp    = alloc_need_rsp_i;
        alloc_entry.is_prefetch = alloc_is_prefetch_i;
    end

    always_comb begin
        for (int w = 0; w < `MSHR_WAYS; w++) begin
            ram_o.wdata[w] = alloc_entry;
            ram_o.wmask[w] = (alloc_way_o == mshr_pkg::mshr_way_t'(w));
        end
    end

    assign ram_o.cs   = ack_i | alloc_i | check_i;
    assign ram_o.we   = alloc_i;
    assign ram_o.addr = ack_i ? ack_set_i : (alloc_i ? alloc_set : check_set);

    assign rrow = ram_o.rdata;

    // Hit needs a valid way with matching tag and cache set
    always_comb begin
        for (int w = 0; w < `MSHR_WAYS; w++) begin
            hit_way[w] = valid_q[check_set_q][w] &&
                         (rrow[w].tag == check_tag_q) &&
                         (cache_set_q[check_set_q][w] == check_cache_set_q);
        end
    end

    assign hit_o        = |hit_way;
    assign alloc_full_o = &valid_q[check_set_q];

    assign empty_o = ~|valid_q;
    assign full_o  = &valid_q;

    // Returned record picked from the row read during the acknowledge
    assign ack_entry         = rrow[ack_way_q];
    assign ack_tag_o         = ack_entry.tag;
    assign ack_req_id_o      = ack_entry.req_id;
    assign ack_src_id_o      = ack_entry.src_id;
    assign ack_word_o        = ack_entry.word_idx;
    assign ack_need_rsp_o    = ack_entry.need_rsp;
    assign ack_is_prefetch_o = ack_entry.is_prefetch;
    assign ack_cache_set_o   = ack_cache_set_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q       <= '0;
            check_nline_q <= '0;
            ack_way_q     <= '0;
        end else begin
            if (alloc_i) begin
                valid_q[alloc_set][alloc_way_o] <= 1'b1;
            end
            if (ack_i) begin
                valid_q[ack_set_i][ack_way_i] <= 1'b0;
                ack_way_q <= ack_way_i;
            end
            if (check) begin
                check_nline_q <= check_nline_i;
            end
        end
    end

    // Cache-set fields are plain payload
    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            cache_set_q[alloc_set][alloc_way_o] <= alloc_nline_i[`CACHE_SET_WIDTH-1:0];
        end
        if (ack_i) begin
            ack_cache_set_q <= cache_set_q[ack_set_i][ack_way_i];
        end
    end

endmodule

`default_nettype wire

/* rtl/mshr_top.sv */
/*
 * MSHR subsystem top: control plus its register bank
 */
`timescale 1ns/1ps
`default_nettype none

`include "mshr_defines.svh"

module mshr_top (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,

    output      logic                   empty_o,
    output      logic                   full_o,

    input  wire logic                   check_i,
    input  wire mshr_pkg::nline_t       check_nline_i,
    output      logic                   hit_o,
    output      logic                   alloc_full_o,

    input  wire logic                   alloc_i,
    input  wire mshr_pkg::nline_t       alloc_nline_i,
    input  wire mshr_pkg::req_id_t      alloc_req_id_i,
    input  wire mshr_pkg::src_id_t      alloc_src_id_i,
    input  wire mshr_pkg::word_t        alloc_word_i,
    input  wire logic                   alloc_need_rsp_i,
    input  wire logic                   alloc_is_prefetch_i,
    output      mshr_pkg::mshr_way_t    alloc_way_o,

    input  wire logic                   ack_i,
    input  wire mshr_pkg::mshr_set_t    ack_set_i,
    input  wire mshr_pkg::mshr_way_t    ack_way_i,
    output      mshr_pkg::req_id_t      ack_req_id_o,
    output      mshr_pkg::src_id_t      ack_src_id_o,
    output      mshr_pkg::cache_set_t   ack_cache_set_o,
    output      mshr_pkg::tag_t         ack_tag_o,
    output      mshr_pkg::word_t        ack_word_o,
    output      logic                   ack_need_rsp_o,
    output      logic                   ack_is_prefetch_o
);

    mshr_ram_if ram_if ();

    mshr u_mshr (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .empty_o             (empty_o),
        .full_o              (full_o),
        .check_i             (check_i),
        .check_nline_i       (check_nline_i),
        .hit_o               (hit_o),
        .alloc_full_o        (alloc_full_o),
        .alloc_i             (alloc_i),
        .alloc_nline_i       (alloc_nline_i),
        .alloc_req_id_i      (alloc_req_id_i),
        .alloc_src_id_i      (alloc_src_id_i),
        .alloc_word_i        (alloc_word_i),
        .alloc_need_rsp_i    (alloc_need_rsp_i),
        .alloc_is_prefetch_i (alloc_is_prefetch_i),
        .alloc_way_o         (alloc_way_o),
        .ack_i               (ack_i),
        .ack_set_i           (ack_set_i),
        .ack_way_i           (ack_way_i),
        .ack_req_id_o        (ack_req_id_o),
        .ack_src_id_o        (ack_src_id_o),
        .ack_cache_set_o     (ack_cache_set_o),
        .ack_tag_o           (ack_tag_o),
        .ack_word_o          (ack_word_o),
        .ack_need_rsp_o      (ack_need_rsp_o),
        .ack_is_prefetch_o   (ack_is_prefetch_o),
        .ram_o               (ram_if.ctrl)
    );

    // One row per MSHR set, one entry per way
    mshr_regbank_1rw #(
        .DEPTH (`MSHR_SETS),
        .row_t (mshr_pkg::mshr_row_t)
    ) u_bank (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .mem_io (ram_if.mem)
    );

endmodule

`default_nettype wire

/* verif/tb_clkgen.sv */
/*
 * Testbench clock and active-low reset generator
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset released on a falling edge, away from the sampling edge
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

`default_nettype wire

/* verif/tb_mshr.sv */
/*
 * MSHR subsystem testbench: reads commands and expected results
 * from the stimulus file, drives the DUT and checks its outputs
 */
`timescale 1ns/1ps
`default_nettype none

`include "mshr_defines.svh"

module tb_mshr;

    localparam int MAX_LINES     = 200;
    localparam int RESET_TIMEOUT = 100;

    localparam int OP_IDLE        = 0;
    localparam int OP_CHECK       = 1;
    localparam int OP_ALLOC       = 2;
    localparam int OP_ACK         = 3;
    localparam int OP_CHECK_ALLOC = 4;

    logic clk;
    logic rst_n;

    // DUT inputs
    logic                  check_i;
    mshr_pkg::nline_t      check_nline_i;
    logic                  alloc_i;
    mshr_pkg::nline_t      alloc_nline_i;
    mshr_pkg::req_id_t     alloc_req_id_i;
    mshr_pkg::src_id_t     alloc_src_id_i;
    mshr_pkg::word_t       alloc_word_i;
    logic                  alloc_need_rsp_i;
    logic                  alloc_is_prefetch_i;
    logic                  ack_i;
    mshr_pkg::mshr_set_t   ack_set_i;
    mshr_pkg::mshr_way_t   ack_way_i;

    // DUT outputs
    logic                  empty_o;
    logic                  full_o;
    logic                  hit_o;
    logic                  alloc_full_o;
    mshr_pkg::mshr_way_t   alloc_way_o;
    mshr_pkg::req_id_t     ack_req_id_o;
    mshr_pkg::src_id_t     ack_src_id_o;
    mshr_pkg::cache_set_t  ack_cache_set_o;
    mshr_pkg::tag_t        ack_tag_o;
    mshr_pkg::word_t       ack_word_o;
    logic                  ack_need_rsp_o;
    logic                  ack_is_prefetch_o;

    // Fields of one stimulus line
    logic [3:0]            f_op;
    mshr_pkg::nline_t      f_line;
    mshr_pkg::req_id_t     f_req;
    mshr_pkg::src_id_t     f_src;
    mshr_pkg::word_t       f_word;
    logic                  f_need;
    logic                  f_pref;
    mshr_pkg::mshr_set_t   f_aset;
    mshr_pkg::mshr_way_t   f_away;
    logic                  e_empty;
    logic                  e_full;
    logic                  e_hit;
    logic                  e_afull;
    mshr_pkg::mshr_way_t   e_way;
    mshr_pkg::nline_t      e_line;
    mshr_pkg::req_id_t     e_req;
    mshr_pkg::src_id_t     e_src;
    mshr_pkg::word_t       e_word;
    logic                  e_need;
    logic                  e_pref;

    int    fd;
    int    code;
    int    num_fields;
    int    num_lines;
    int    num_ops;
    int    cycles;
    string text;

    tb_clkgen u_clkgen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    mshr_top UUT (
        .clk_i               (clk),
        .rst_ni              (rst_n),
        .empty_o             (empty_o),
        .full_o              (full_o),
        .check_i             (check_i),
        .check_nline_i       (check_nline_i),
        .hit_o               (hit_o),
        .alloc_full_o        (alloc_full_o),
        .alloc_i             (alloc_i),
        .alloc_nline_i       (alloc_nline_i),
        .alloc_req_id_i      (alloc_req_id_i),
        .alloc_src_id_i      (alloc_src_id_i),
        .alloc_word_i        (alloc_word_i),
        .alloc_need_rsp_i    (alloc_need_rsp_i),
        .alloc_is_prefetch_i (alloc_is_prefetch_i),
        .alloc_way_o         (alloc_way_o),
        .ack_i               (ack_i),
        .ack_set_i           (ack_set_i),
        .ack_way_i           (ack_way_i),
        .ack_req_id_o        (ack_req_id_o),
        .ack_src_id_o        (ack_src_id_o),
        .ack_cache_set_o     (ack_cache_set_o),
        .ack_tag_o           (ack_tag_o),
        .ack_word_o          (ack_word_o),
        .ack_need_rsp_o      (ack_need_rsp_o),
        .ack_is_prefetch_o   (ack_is_prefetch_o)
    );

    task automatic check_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        assert (act === exp) else begin
            $display("[FAIL] %0t: %s expected %0h, got %0h", $time, name, exp, act);
            $display("Test failed");
            $fatal(1, "Output mismatch");
        end
    endtask

    function automatic bit is_skipped(input string line);
        if (line.len() == 0) begin
            return 1'b1;
        end
        return (line.getc(0) == "#") || (line.getc(0) == "\n") || (line.getc(0) == "\r");
    endfunction

    // Strobes from the op code, payload straight from the line
    task automatic drive_command();
        check_i             = (f_op == OP_CHECK) || (f_op == OP_CHECK_ALLOC);
        alloc_i             = (f_op == OP_ALLOC) || (f_op == OP_CHECK_ALLOC);
        ack_i               = (f_op == OP_ACK);
        check_nline_i       = f_line;
        alloc_nline_i       = f_line;
        alloc_req_id_i      = f_req;
        alloc_src_id_i      = f_src;
        alloc_word_i        = f_word;
        alloc_need_rsp_i    = f_need;
        alloc_is_prefetch_i = f_pref;
        ack_set_i           = f_aset;
        ack_way_i           = f_away;
    endtask

    task automatic drive_idle();
        f_op   = 4'(OP_IDLE);
        f_line = '0;
        f_req  = '0;
        f_src  = '0;
        f_word = '0;
        f_need = 1'b0;
        f_pref = 1'b0;
        f_aset = '0;
        f_away = '0;
        drive_command();
    endtask

    // Outputs of the cycle after the command
    task automatic check_results();
        check_value("empty_o", 32'(empty_o), 32'(e_empty));
        check_value("full_o", 32'(full_o), 32'(e_full));
        if (f_op == OP_CHECK) begin
            check_value("hit_o", 32'(hit_o), 32'(e_hit));
            check_value("alloc_full_o", 32'(alloc_full_o), 32'(e_afull));
        end
        if (f_op == OP_ACK) begin
            // Tag is the upper line bits, cache set the lower ones
            check_value("ack_tag_o", 32'(ack_tag_o),
                        32'(e_line[`NLINE_WIDTH-1 -: `TAG_WIDTH]));
            check_value("ack_cache_set_o", 32'(ack_cache_set_o),
                        32'(e_line[`CACHE_SET_WIDTH-1:0]));
            check_value("ack_req_id_o", 32'(ack_req_id_o), 32'(e_req));
            check_value("ack_src_id_o", 32'(ack_src_id_o), 32'(e_src));
            check_value("ack_word_o", 32'(ack_word_o), 32'(e_word));
            check_value("ack_need_rsp_o", 32'(ack_need_rsp_o), 32'(e_need));
            check_value("ack_is_prefetch_o", 32'(ack_is_prefetch_o), 32'(e_pref));
        end
    endtask

    initial begin
        drive_idle();
        num_lines = 0;
        num_ops   = 0;

        fd = $fopen("verif/mshr_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file verif/mshr_stimulus.txt");
            $display("Test failed");
            $fatal(1, "No stimulus");
        end

        cycles = 0;
        while (rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was still asserted after %0d cycles", RESET_TIMEOUT);
            $display("Test failed");
            $fatal(1, "Reset timeout");
        end

        // Idle state straight after reset
        check_value("empty_o", 32'(empty_o), 32'd1);
        check_value("full_o", 32'(full_o), 32'd0);

        while (!$feof(fd) && num_lines < MAX_LINES) begin
            text = "";
            code = $fgets(text, fd);
            num_lines++;
            if (code == 0 || is_skipped(text)) begin
                continue;
            end
            num_fields = $sscanf(text,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                f_op, f_line, f_req, f_src, f_word, f_need, f_pref, f_aset, f_away,
                e_empty, e_full, e_hit, e_afull, e_way,
                e_line, e_req, e_src, e_word, e_need, e_pref);
            if (num_fields != 20 || f_op > OP_CHECK_ALLOC) begin
                $display("Stimulus line %0d is malformed: %s", num_lines, text);
                $display("Test failed");
                $fatal(1, "Bad stimulus");
            end

            drive_command();
            num_ops++;
            if (f_op == OP_ALLOC || f_op == OP_CHECK_ALLOC) begin
                // Way choice is combinational, sampled mid-cycle
                #1;
                check_value("alloc_way_o", 32'(alloc_way_o), 32'(e_way));
            end
            @(negedge clk);
            check_results();
        end
        $fclose(fd);
        drive_idle();

        if (num_ops > 0) begin
            $display("Checked %0d commands", num_ops);
            $display("Test passed");
            $finish;
        end else begin
            $display("The stimulus file held no commands");
            $display("Test failed");
            $fatal(1, "Empty stimulus");
        end
    end

endmodule

`default_nettype wire

/* verif/mshr_stimulus.txt */
# op: 0 idle, 1 check, 2 alloc, 3 ack, 4 check with alloc; every field in hex
# op line req src wrd nr pf aset away  empty full hit afull way  eline ereq esrc ewrd enr epf
# Reset state
1 1234 0 0 0 0 0 0 0   1 0 0 0 0   0000 0 0 0 0 0
0 0000 0 0 0 0 0 0 0   1 0 0 0 0   0000 0 0 0 0 0
# Hit after allocate, miss on another tag or cache set
2 1235 3 1 5 1 0 0 0   0 0 0 0 0   0000 0 0 0 0 0
1 1235 0 0 0 0 0 0 0   0 0 1 0 0   0000 0 0 0 0 0
1 2235 0 0 0 0 0 0 0   0 0 0 0 0   0000 0 0 0 0 0
1 1239 0 0 0 0 0 0 0   0 0 0 0 0   0000 0 0 0 0 0
# Second way of set 1, set then full
2 abc5 7 2 1 0 1 0 0   0 0 0 0 1   0000 0 0 0 0 0
1 0001 0 0 0 0 0 0 0   0 0 0 1 0   0000 0 0 0 0 0
1 abc5 0 0 0 0 0 0 0   0 0 1 1 0   0000 0 0 0 0 0
# Fill the remaining six slots
2 0100 1 0 0 1 0 0 0   0 0 0 0 0   0000 0 0 0 0 0
2 0204 2 3 2 0 0 0 0   0 0 0 0 1   0000 0 0 0 0 0
2 0302 4 1 3 1 1 0 0   0 0 0 0 0   0000 0 0 0 0 0
2 0406 5 2 4 1 0 0 0   0 0 0 0 1   0000 0 0 0 0 0
2 0503 6 0 6 0 1 0 0   0 0 0 0 0   0000 0 0 0 0 0
2 0607 8 3 7 1 1 0 0   0 1 0 0 1   0000 0 0 0 0 0
1 0302 0 0 0 0 0 0 0   0 1 1 1 0   0000 0 0 0 0 0
# Acknowledge returns the record, the freed way is reused
3 0000 0 0 0 0 0 1 0   0 0 0 0 0   1235 3 1 5 1 0
1 1235 0 0 0 0 0 0 0   0 0 0 0 0   0000 0 0 0 0 0
2 7775 9 2 6 0 1 0 0   0 1 0 0 0   0000 0 0 0 0 0
# Check together with alloc, the allocation wins
3 0000 0 0 0 0 0 2 1   0 0 0 0 0   0406 5 2 4 1 0
4 1a1e a 1 2 1 1 0 0   0 1 0 0 1   0000 0 0 0 0 0
1 1a1e 0 0 0 0 0 0 0   0 1 1 1 0   0000 0 0 0 0 0
# Drain every slot
3 0000 0 0 0 0 0 0 0   0 0 0 0 0   0100 1 0 0 1 0
3 0000 0 0 0 0 0 0 1   0 0 0 0 0   0204 2 3 2 0 0
3 0000 0 0 0 0 0 1 0   0 0 0 0 0   7775 9 2 6 0 1
3 0000 0 0 0 0 0 1 1   0 0 0 0 0   abc5 7 2 1 0 1
3 0000 0 0 0 0 0 2 0   0 0 0 0 0   0302 4 1 3 1 1
3 0000 0 0 0 0 0 2 1   0 0 0 0 0   1a1e a 1 2 1 1
3 0000 0 0 0 0 0 3 0   0 0 0 0 0   0503 6 0 6 0 1
3 0000 0 0 0 0 0 3 1   1 0 0 0 0   0607 8 3 7 1 1
1 0607 0 0 0 0 0 0 0   1 0 0 0 0   0000 0 0 0 0 0
0 0000 0 0 0 0 0 0 0   1 0 0 0 0   0000 0 0 0 0 0

/* list.f */
+incdir+rtl
rtl/mshr_pkg.sv
rtl/mshr_ram_if.sv
rtl/mshr_regbank_1rw.sv
rtl/mshr.sv
rtl/mshr_top.sv
verif/tb_clkgen.sv
verif/tb_mshr.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_mshr
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
